/* pciBusPkg.sv */
`default_nettype none

package pciBusPkg;

  ////////////////////
  // bus widths
  ////////////////////
  localparam int adWidth        = 32;  // multiplexed address/data
  localparam int cbeWidth       = 4;   // command in address phase, byte enables after
  localparam int dwordAddrWidth = 4;   // 16 dwords per window

  ////////////////////
  // command codes
  ////////////////////
  localparam logic [cbeWidth-1:0] cmdIoRead             = 4'b0010;
  localparam logic [cbeWidth-1:0] cmdIoWrite            = 4'b0011;
  localparam logic [cbeWidth-1:0] cmdMemRead            = 4'b0110;
  localparam logic [cbeWidth-1:0] cmdMemWrite           = 4'b0111;
  localparam logic [cbeWidth-1:0] cmdCfgRead            = 4'b1010;
  localparam logic [cbeWidth-1:0] cmdCfgWrite           = 4'b1011;
  localparam logic [cbeWidth-1:0] cmdMemReadMultiple    = 4'b1100;
  localparam logic [cbeWidth-1:0] cmdMemReadLine        = 4'b1110;
  localparam logic [cbeWidth-1:0] cmdMemWriteInvalidate = 4'b1111;
  // bit 0 of every code above is the write flag

  ////////////////////
  // BAR base fields
  ////////////////////
  localparam int bar0Width = 10;  // AD[15:6], 64 byte I/O window
  localparam int bar1Width = 16;  // AD[31:16], 64 KB memory window

  // address phase word
  // same 32 bits, seen through BAR0 or BAR1
  typedef union packed {
    struct packed {
      logic [15:0]               upper;    // ignored by the I/O decode
      logic [bar0Width-1:0]      ioBase;   // compared with BAR0
      logic [dwordAddrWidth-1:0] dword;    // register index
      logic [1:0]                byteSel;  // must be zero for I/O
    } ioView;
    struct packed {
      logic [bar1Width-1:0]      memBase;    // compared with BAR1
      logic [9:0]                lowOffset;  // rest of the 64 KB, not decoded
      logic [dwordAddrWidth-1:0] dword;
      logic [1:0]                byteSel;    // burst order bits for memory
    } memView;
  } pciAddrWord;

endpackage

`default_nettype wire

/* pciDevicePkg.sv */
`default_nettype none

package pciDevicePkg;

  ////////////////////
  // device identity
  ////////////////////
  localparam logic [15:0] vendorId  = 16'h0100;  // must match the driver INF
  localparam logic [15:0] deviceId  = 16'h0001;
  localparam logic [31:0] classCode = 32'h0880_0000;  // other system peripheral, rev 0

  ////////////////////
  // configuration dword offsets
  ////////////////////
  localparam logic [pciBusPkg::dwordAddrWidth-1:0] cfgIdOffset      = 4'h0;
  localparam logic [pciBusPkg::dwordAddrWidth-1:0] cfgCommandOffset = 4'h1;  // status above
  localparam logic [pciBusPkg::dwordAddrWidth-1:0] cfgClassOffset   = 4'h2;
  localparam logic [pciBusPkg::dwordAddrWidth-1:0] cfgBar0Offset    = 4'h4;  // 10h
  localparam logic [pciBusPkg::dwordAddrWidth-1:0] cfgBar1Offset    = 4'h5;  // 14h

  // BAR0 low bits, I/O space indicator
  localparam logic [5:0] bar0TypeBits = 6'b000001;

  ////////////////////
  // user register window
  ////////////////////
  localparam logic [pciBusPkg::dwordAddrWidth-1:0] regSignatureOffset = 4'h0;
  localparam logic [pciBusPkg::dwordAddrWidth-1:0] regLedOffset       = 4'h1;
  localparam logic [pciBusPkg::dwordAddrWidth-1:0] regStatusOffset    = 4'h2;

  // signature words, one per BAR
  // lets the driver tell which window it is reading
  localparam logic [pciBusPkg::adWidth-1:0] ioSignature  = 32'h0000_4F49;  // "OI"
  localparam logic [pciBusPkg::adWidth-1:0] memSignature = 32'h004D_454D;  // "MEM"

  localparam int ledWidth = 3;  // LED register bits

endpackage

`default_nettype wire

/* pciTargetCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pciTargetCtrl (
  input  wire                                  PCI_CLK,
  input  wire                                  PCI_RSTn,
  input  wire                                  frameN,
  input  wire                                  irdyN,
  input  wire                                  idsel,
  input  wire [pciBusPkg::cbeWidth-1:0]        cbe,
  input  wire pciBusPkg::pciAddrWord           adIn,
  input  wire                                  ioEnabled,
  input  wire                                  memEnabled,
  input  wire [pciBusPkg::bar0Width-1:0]       bar0,
  input  wire [pciBusPkg::bar1Width-1:0]       bar1,
  input  wire [pciBusPkg::adWidth-1:0]         cfgReadData,
  input  wire [pciBusPkg::adWidth-1:0]         regReadData,
  output logic                                 devselN,
  output logic                                 trdyN,
  output logic                                 stopN,
  output logic                                 claimOe,
  output logic [pciBusPkg::adWidth-1:0]        adOut,
  output logic                                 adOe,
  output logic [pciBusPkg::dwordAddrWidth-1:0] transAddr,
  output logic                                 cfgWrite,
  output logic                                 regWrite,
  output logic                                 regIoSpace,
  output logic                                 regReadIoSpace
);
  import pciBusPkg::*;

  logic transaction;      // bus busy
  logic wasLastTransfer;  // last data phase on previous edge
  logic dataTransfer;
  logic lastTransfer;
  logic transStart;
  logic transEnd;
  logic cmdIsIo;
  logic cmdIsMem;
  logic cmdIsCfg;
  logic targeted;
  logic devSel;
  logic targetReady;
  logic readNotWrite;
  logic ioSpace;
  logic memSpace;
  logic cfgSpace;

  ////////////////////
  // transaction tracking
  ////////////////////
  assign dataTransfer = !irdyN && targetReady;  // our TRDYn is low
  assign lastTransfer = dataTransfer && frameN;

  // initial start from idle, or fast back-to-back right after our last phase
  assign transStart = (!transaction || wasLastTransfer) && !frameN;
  assign transEnd   = transaction && frameN && irdyN;  // bus idle

  always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
    if (!PCI_RSTn) begin
      transaction     <= 1'b0;
      wasLastTransfer <= 1'b0;
    end else begin
      wasLastTransfer <= lastTransfer;
      if (!transaction)
        transaction <= transStart;
      else
        transaction <= !transEnd;  // back-to-back keeps it set
    end
  end

  ////////////////////
  // address phase decode
  ////////////////////
  assign cmdIsIo  = (cbe == cmdIoRead) || (cbe == cmdIoWrite);
  assign cmdIsMem = (cbe == cmdMemRead) || (cbe == cmdMemReadMultiple) ||
                    (cbe == cmdMemReadLine) || (cbe == cmdMemWrite) ||
                    (cbe == cmdMemWriteInvalidate);
  assign cmdIsCfg = (cbe == cmdCfgRead) || (cbe == cmdCfgWrite);

  assign targeted = transStart && (
    (cmdIsIo && ioEnabled && (adIn.ioView.ioBase == bar0) && (adIn.ioView.byteSel == 2'b00)) ||
    (cmdIsMem && memEnabled && (adIn.memView.memBase == bar1)) ||
    (cmdIsCfg && idsel && (adIn.ioView.byteSel == 2'b00))   // type 0 only
  );

  // space and direction held for the whole transaction
  always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
    if (!PCI_RSTn) begin
      readNotWrite <= 1'b0;
      ioSpace      <= 1'b0;
      memSpace     <= 1'b0;
      cfgSpace     <= 1'b0;
    end else if (transStart) begin
      readNotWrite <= !cbe[0];
      ioSpace      <= cmdIsIo;
      memSpace     <= cmdIsMem;
      cfgSpace     <= cmdIsCfg;
    end
  end

  // dword address, loaded at the address phase, bumped per data phase
  always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
    if (!PCI_RSTn)
      transAddr <= '0;
    else if (transStart)
      transAddr <= adIn.ioView.dword;  // same bits in both views
    else if (dataTransfer)
      transAddr <= transAddr + 1'b1;   // wraps within the window
  end

  ////////////////////
  // target handshake
  ////////////////////
  always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
    if (!PCI_RSTn) begin
      claimOe     <= 1'b0;
      devSel      <= 1'b0;
      targetReady <= 1'b0;
      adOe        <= 1'b0;
    end else begin
      if (transStart)
        claimOe <= targeted;
      else if (transEnd)
        claimOe <= 1'b0;  // release on idle
      if (transStart)
        devSel <= targeted;  // fast decode
      else
        devSel <= devSel && !lastTransfer;
      if (transStart)
        targetReady <= targeted && cbe[0];  // writes ready at once
      else
        targetReady <= devSel && !lastTransfer;  // reads one edge later
      // turnaround cycle before driving AD
      adOe <= devSel && readNotWrite && !lastTransfer;
    end
  end

  assign devselN = !devSel;
  assign trdyN   = !targetReady;
  assign stopN   = 1'b1;  // no disconnect, bursts run freely

  ////////////////////
  // write strobes and read data
  ////////////////////
  assign cfgWrite = devSel && cfgSpace && !readNotWrite && dataTransfer;
  assign regWrite = devSel && (ioSpace || memSpace) && !readNotWrite && dataTransfer;

  assign regIoSpace     = ioSpace;  // which BAR took the write
  assign regReadIoSpace = ioSpace;  // picks the I/O read view

  assign adOut = (ioSpace || memSpace) ? regReadData : cfgReadData;

endmodule

`default_nettype wire

/* pciConfigSpace.sv */
`timescale 1ns/1ps
`default_nettype none

module pciConfigSpace (
  input  wire                                  PCI_CLK,
  input  wire                                  PCI_RSTn,
  input  wire [pciBusPkg::dwordAddrWidth-1:0]  transAddr,
  input  wire                                  cfgWrite,
  input  wire [pciBusPkg::adWidth-1:0]         adIn,
  output logic                                 ioEnabled,
  output logic                                 memEnabled,
  output logic [pciBusPkg::bar0Width-1:0]      bar0,
  output logic [pciBusPkg::bar1Width-1:0]      bar1,
  output logic [pciBusPkg::adWidth-1:0]        cfgReadData
);
  import pciBusPkg::*;
  import pciDevicePkg::*;

  ////////////////////
  // command register
  ////////////////////
  always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
    if (!PCI_RSTn) begin
      ioEnabled  <= 1'b0;
      memEnabled <= 1'b0;
    end else if (cfgWrite && (transAddr == cfgCommandOffset)) begin
      ioEnabled  <= adIn[0];  // I/O space enable
      memEnabled <= adIn[1];  // memory space enable
    end
  end

  ////////////////////
  // base address registers
  ////////////////////
  always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
    if (!PCI_RSTn)
      bar0 <= '0;
    else if (cfgWrite && (transAddr == cfgBar0Offset))
      bar0 <= adIn[6 +: bar0Width];  // AD[15:6]
  end

  always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
    if (!PCI_RSTn)
      bar1 <= '0;
    else if (cfgWrite && (transAddr == cfgBar1Offset))
      bar1 <= adIn[adWidth-1 -: bar1Width];  // AD[31:16]
  end

  // read decode
  // follows transAddr, no register stage
  always_comb begin
    case (transAddr)
      cfgIdOffset:
        cfgReadData = {deviceId, vendorId};
      cfgCommandOffset:
        // status all zero, DEVSEL timing reads fast
        cfgReadData = {16'h0000, 14'h0000, memEnabled, ioEnabled};
      cfgClassOffset:
        cfgReadData = classCode;
      cfgBar0Offset:
        cfgReadData = {16'h0000, bar0, bar0TypeBits};  // 64 byte I/O
      cfgBar1Offset:
        cfgReadData = {bar1, 16'h0000};  // 64 KB memory, 32 bit, not prefetchable
      default:
        cfgReadData = '0;  // header type, subsystem, interrupt all zero
    endcase
  end

endmodule

`default_nettype wire

/* pciUserRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module pciUserRegs (
  input  wire                                  PCI_CLK,
  input  wire                                  PCI_RSTn,
  input  wire [pciBusPkg::dwordAddrWidth-1:0]  transAddr,
  input  wire                                  regWrite,
  input  wire                                  regIoSpace,
  input  wire                                  regReadIoSpace,
  input  wire [pciBusPkg::adWidth-1:0]         adIn,
  output logic [1:0]                           led,
  output logic [pciBusPkg::adWidth-1:0]        regReadData
);
  import pciBusPkg::*;
  import pciDevicePkg::*;

  logic [ledWidth-1:0] ledReg;
  logic [adWidth-1:0]  statusReg;  // free scratch word for the driver

  ////////////////////
  // register writes
  ////////////////////
  always_ff @(posedge PCI_CLK or negedge PCI_RSTn) begin
    if (!PCI_RSTn) begin
      ledReg    <= '0;
      statusReg <= '0;
    end else if (regWrite) begin
      case (transAddr)
        regLedOffset:
          if (regIoSpace)
            ledReg <= adIn[ledWidth +: ledWidth];  // AD[5:3]
          else
            ledReg <= adIn[ledWidth-1:0];          // AD[2:0]
        regStatusOffset:
          statusReg <= adIn;
        default: ;  // signature is read only
      endcase
    end
  end

  ////////////////////
  // read decode
  ////////////////////
  always_comb begin
    case (transAddr)
      regSignatureOffset:
        regReadData = regReadIoSpace ? ioSignature : memSignature;
      regLedOffset:
        if (regReadIoSpace)
          regReadData = {{(adWidth-2*ledWidth){1'b0}}, ledReg, {ledWidth{1'b0}}};  // back at 5:3
        else
          regReadData = {{(adWidth-ledWidth){1'b0}}, ledReg};
      regStatusOffset:
        regReadData = statusReg;
      default:
        regReadData = '0;
    endcase
  end

  assign led = ledReg[1:0];  // only two LEDs on the board

endmodule

`default_nettype wire

/* pciTarget.sv */
`timescale 1ns/1ps
`default_nettype none

module pciTarget (
  input  wire                             PCI_CLK,
  input  wire                             PCI_RSTn,
  input  wire                             PCI_FRAMEn,
  input  wire                             PCI_IRDYn,
  input  wire                             PCI_IDSEL,
  input  wire [pciBusPkg::cbeWidth-1:0]   PCI_CBE,
  inout  wire [pciBusPkg::adWidth-1:0]    PCI_AD,
  inout  wire                             PCI_DEVSELn,
  inout  wire                             PCI_TRDYn,
  inout  wire                             PCI_STOPn,
  output logic [1:0]                      LED
);
  import pciBusPkg::*;

  logic                      devselN;
  logic                      trdyN;
  logic                      stopN;
  logic                      claimOe;  // owns DEVSELn/TRDYn/STOPn
  logic [adWidth-1:0]        adOut;
  logic                      adOe;
  logic [dwordAddrWidth-1:0] transAddr;
  logic                      cfgWrite;
  logic                      regWrite;
  logic                      regIoSpace;
  logic                      regReadIoSpace;
  logic                      ioEnabled;
  logic                      memEnabled;
  logic [bar0Width-1:0]      bar0;
  logic [bar1Width-1:0]      bar1;
  logic [adWidth-1:0]        cfgReadData;
  logic [adWidth-1:0]        regReadData;

  ////////////////////
  // pin drivers
  ////////////////////
  assign PCI_AD      = adOe ? adOut : 'z;  // reads only, after turnaround
  assign PCI_DEVSELn = claimOe ? devselN : 1'bz;
  assign PCI_TRDYn   = claimOe ? trdyN : 1'bz;
  assign PCI_STOPn   = claimOe ? stopN : 1'bz;  // held high while claimed

  pciTargetCtrl ctrl (
    .PCI_CLK(PCI_CLK), .PCI_RSTn(PCI_RSTn),
    .frameN(PCI_FRAMEn), .irdyN(PCI_IRDYn), .idsel(PCI_IDSEL), .cbe(PCI_CBE), .adIn(PCI_AD),
    .ioEnabled(ioEnabled), .memEnabled(memEnabled), .bar0(bar0), .bar1(bar1),
    .cfgReadData(cfgReadData), .regReadData(regReadData),
    .devselN(devselN), .trdyN(trdyN), .stopN(stopN), .claimOe(claimOe),
    .adOut(adOut), .adOe(adOe), .transAddr(transAddr),
    .cfgWrite(cfgWrite), .regWrite(regWrite),
    .regIoSpace(regIoSpace), .regReadIoSpace(regReadIoSpace)
  );

  pciConfigSpace cfgSpace (
    .PCI_CLK(PCI_CLK), .PCI_RSTn(PCI_RSTn),
    .transAddr(transAddr), .cfgWrite(cfgWrite), .adIn(PCI_AD),
    .ioEnabled(ioEnabled), .memEnabled(memEnabled), .bar0(bar0), .bar1(bar1),
    .cfgReadData(cfgReadData)
  );

  pciUserRegs userRegs (
    .PCI_CLK(PCI_CLK), .PCI_RSTn(PCI_RSTn),
    .transAddr(transAddr), .regWrite(regWrite), .regIoSpace(regIoSpace),
    .regReadIoSpace(regReadIoSpace), .adIn(PCI_AD),
    .led(LED), .regReadData(regReadData)
  );

endmodule

`default_nettype wire

/* pciTarget_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module pciTargetAsserts (
  input wire                           PCI_CLK,
  input wire                           PCI_RSTn,
  input wire                           PCI_FRAMEn,
  input wire                           PCI_IDSEL,
  input wire [pciBusPkg::cbeWidth-1:0] PCI_CBE,
  input wire [pciBusPkg::adWidth-1:0]  PCI_AD,
  input wire                           PCI_DEVSELn,
  input wire                           PCI_TRDYn,
  input wire                           claimOe,
  input wire                           adOe,
  input wire                           ioEnabled,
  input wire                           memEnabled,
  input wire [pciBusPkg::bar0Width-1:0] bar0,
  input wire [pciBusPkg::bar1Width-1:0] bar1
);
  import pciBusPkg::*;

  int failCount = 0;
  logic frameWasHigh;  // FRAMEn high on the previous edge
  logic addrPhase;
  logic decodeHit;

  always @(posedge PCI_CLK) frameWasHigh <= PCI_FRAMEn;

  assign addrPhase = !PCI_FRAMEn && frameWasHigh;  // initial and back-to-back starts
  assign decodeHit =
    ((PCI_CBE == cmdIoRead || PCI_CBE == cmdIoWrite) && ioEnabled &&
     PCI_AD[15:6] == bar0 && PCI_AD[1:0] == 2'b00) ||
    ((PCI_CBE == cmdMemRead || PCI_CBE == cmdMemWrite || PCI_CBE == cmdMemReadMultiple ||
      PCI_CBE == cmdMemReadLine || PCI_CBE == cmdMemWriteInvalidate) &&
     memEnabled && PCI_AD[31:16] == bar1) ||
    ((PCI_CBE == cmdCfgRead || PCI_CBE == cmdCfgWrite) && PCI_IDSEL && PCI_AD[1:0] == 2'b00);

  ////////////////////
  // reset and drive rules
  ////////////////////
  resetQuiet: assert property (@(posedge PCI_CLK) !PCI_RSTn |-> !claimOe && !adOe)
    else begin $error("claim or AD drive within reset"); failCount++; end

  trdyInsideDevsel: assert property (@(posedge PCI_CLK) disable iff (!PCI_RSTn)
    PCI_TRDYn === 1'b0 |-> PCI_DEVSELn === 1'b0)
    else begin $error("TRDYn low without DEVSELn"); failCount++; end

  adOnlyWithTrdy: assert property (@(posedge PCI_CLK) disable iff (!PCI_RSTn)
    adOe |-> PCI_TRDYn === 1'b0 && PCI_DEVSELn === 1'b0)  // read turnaround already passed
    else begin $error("AD driven outside a read data phase"); failCount++; end

  ////////////////////
  // DEVSELn timing
  ////////////////////
  devselFast: assert property (@(posedge PCI_CLK) disable iff (!PCI_RSTn)
    addrPhase && decodeHit |=> PCI_DEVSELn === 1'b0)
    else begin $error("DEVSELn missing after a matching address"); failCount++; end

  devselNoMatch: assert property (@(posedge PCI_CLK) disable iff (!PCI_RSTn)
    addrPhase && !decodeHit |=> PCI_DEVSELn !== 1'b0)
    else begin $error("DEVSELn on an address outside the decode"); failCount++; end

endmodule

bind pciTarget pciTargetAsserts protoChecks (
  .PCI_CLK(PCI_CLK), .PCI_RSTn(PCI_RSTn), .PCI_FRAMEn(PCI_FRAMEn), .PCI_IDSEL(PCI_IDSEL),
  .PCI_CBE(PCI_CBE), .PCI_AD(PCI_AD), .PCI_DEVSELn(PCI_DEVSELn), .PCI_TRDYn(PCI_TRDYn),
  .claimOe(claimOe), .adOe(adOe), .ioEnabled(ioEnabled), .memEnabled(memEnabled),
  .bar0(bar0), .bar1(bar1)
);

`default_nettype wire

/* tbPciTarget.sv */
`timescale 1ns/1ps
`default_nettype none

module tbPciTarget;
  import pciBusPkg::*;
  import pciDevicePkg::*;

  localparam int clkPeriod = 100;
  localparam int testCycles = 40 * 12;  // about 40 transactions of at most 12 cycles
  localparam logic [31:0] ioBase = 32'h0000_1240;
  localparam logic [31:0] memBase = 32'h8765_0000;

  logic PCI_CLK = 1'b1;  // first edge is falling
  logic PCI_RSTn = 1'b1;
  logic PCI_FRAMEn = 1'b1;
  logic PCI_IRDYn = 1'b1;
  logic PCI_IDSEL = 1'b0;
  logic [cbeWidth-1:0] PCI_CBE = '0;
  logic [adWidth-1:0] adMaster = '0;
  logic adDrive = 1'b0;
  wire [adWidth-1:0] PCI_AD;
  wire PCI_DEVSELn;
  wire PCI_TRDYn;
  wire PCI_STOPn;
  wire [1:0] LED;
  logic [31:0] wrBuf [16];
  logic [31:0] rdBuf [16];
  int errors = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int errorsBefore = 0;
  int total;

  pullup (PCI_DEVSELn);
  pullup (PCI_TRDYn);
  pullup (PCI_STOPn);
  assign PCI_AD = adDrive ? adMaster : 'z;  // master side of AD

  pciTarget UUT (
    .PCI_CLK(PCI_CLK), .PCI_RSTn(PCI_RSTn), .PCI_FRAMEn(PCI_FRAMEn), .PCI_IRDYn(PCI_IRDYn),
    .PCI_IDSEL(PCI_IDSEL), .PCI_CBE(PCI_CBE), .PCI_AD(PCI_AD), .PCI_DEVSELn(PCI_DEVSELn),
    .PCI_TRDYn(PCI_TRDYn), .PCI_STOPn(PCI_STOPn), .LED(LED)
  );

  always #(clkPeriod / 2) PCI_CLK = !PCI_CLK;

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // one master transaction, called and returning at a falling edge
  task automatic busXfer(input logic [3:0] cmd, input logic [31:0] addr, input logic sel,
                         input int count, input bit stalls, input bit b2b, input bit expClaim);
    int waits;
    int turn;
    PCI_FRAMEn = 1'b0;
    PCI_IRDYn = 1'b1;
    PCI_CBE = cmd;
    PCI_IDSEL = sel;
    adMaster = addr;
    adDrive = 1'b1;
    @(negedge PCI_CLK);
    checkValue("DEVSELn after address phase", PCI_DEVSELn, !expClaim);
    PCI_IDSEL = 1'b0;
    PCI_CBE = 4'h0;  // all byte enables on
    if (PCI_DEVSELn !== 1'b0) begin  // master abort, shortened
      PCI_FRAMEn = 1'b1;
      adDrive = 1'b0;
      @(negedge PCI_CLK);
      checkValue("DEVSELn on unclaimed access", PCI_DEVSELn, 1'b1);
      return;
    end
    for (int i = 0; i < count; i++) begin
      waits = stalls ? $urandom_range(2) : 0;
      repeat (waits) begin  // IRDYn wait states
        PCI_IRDYn = 1'b1;
        adDrive = cmd[0];
        adMaster = wrBuf[i];
        @(negedge PCI_CLK);
      end
      PCI_IRDYn = 1'b0;
      PCI_FRAMEn = (i == count - 1);  // last phase
      adDrive = cmd[0];
      adMaster = wrBuf[i];
      turn = 0;
      while (PCI_TRDYn !== 1'b0 && turn < 4) begin
        turn++;
        @(negedge PCI_CLK);
      end
      // reads lose one cycle to turnaround unless a stall covered it
      checkValue("TRDYn wait cycles", turn, (i == 0 && !cmd[0] && waits == 0) ? 1 : 0);
      checkValue("STOPn", PCI_STOPn, 1'b1);  // target never disconnects
      if (!cmd[0])
        rdBuf[i] = PCI_AD;
      @(negedge PCI_CLK);
    end
    checkValue("DEVSELn after last phase", PCI_DEVSELn, 1'b1);
    if (!b2b) begin
      PCI_IRDYn = 1'b1;
      adDrive = 1'b0;
      @(negedge PCI_CLK);
    end
  endtask

  task automatic readCheck(input logic [3:0] cmd, input logic [31:0] addr, input logic sel,
                           input logic [31:0] exp, input bit expClaim, input bit b2b);
    rdBuf[0] = 'x;
    busXfer(cmd, addr, sel, 1, 1'b0, b2b, expClaim);
    if (expClaim)
      checkValue("PCI_AD read data", rdBuf[0], exp);
  endtask

  task automatic writeDo(input logic [3:0] cmd, input logic [31:0] addr, input logic sel,
                         input logic [31:0] data, input bit b2b);
    wrBuf[0] = data;
    busXfer(cmd, addr, sel, 1, 1'b0, b2b, 1'b1);
  endtask

  task automatic endTest(input string name);
    testsRun++;
    if (errors != errorsBefore)
      testsFailed++;
    $display("test %0d %s: %s", testsRun, name, (errors == errorsBefore) ? "ok" : "failed");
    errorsBefore = errors;
  endtask

  initial begin  // watchdog
    #(testCycles * clkPeriod + 100 * clkPeriod);
    $display("watchdog expired, the tests did not finish in time");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h8fd0));
    @(negedge PCI_CLK);
    PCI_RSTn = 1'b0;  // held over two rising edges
    repeat (2) @(negedge PCI_CLK);
    PCI_RSTn = 1'b1;
    @(negedge PCI_CLK);

    readCheck(cmdIoRead, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);  // enables still off
    readCheck(cmdMemRead, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0);
    // device 0001, vendor 0100
    readCheck(cmdCfgRead, {24'h0, cfgIdOffset, 2'b00}, 1'b1, 32'h0001_0100, 1'b1, 1'b0);
    endTest("reset and no claim");

    writeDo(cmdCfgWrite, 32'h4, 1'b1, 32'h0000_0003, 1'b0);   // I/O and memory on
    writeDo(cmdCfgWrite, 32'h10, 1'b1, ioBase | 32'hFFFF_0003, 1'b0);
    writeDo(cmdCfgWrite, 32'h14, 1'b1, memBase | 32'h0000_4321, 1'b0);
    readCheck(cmdCfgRead, 32'h4, 1'b1, 32'h0000_0003, 1'b1, 1'b0);
    readCheck(cmdCfgRead, 32'h10, 1'b1, {16'h0, ioBase[15:6], 6'b000001}, 1'b1, 1'b0);
    readCheck(cmdCfgRead, 32'h14, 1'b1, memBase, 1'b1, 1'b0);
    readCheck(cmdCfgRead, 32'h0C, 1'b1, 32'h0, 1'b1, 1'b0);
    readCheck(cmdCfgRead, 32'h3C, 1'b1, 32'h0, 1'b1, 1'b0);
    endTest("configuration round trip");

    readCheck(cmdIoRead, ioBase + 32'h40, 1'b0, 32'h0, 1'b0, 1'b0);  // next I/O window
    readCheck(cmdIoRead, ioBase + 32'h1, 1'b0, 32'h0, 1'b0, 1'b0);   // byte bits set
    readCheck(cmdMemRead, memBase + 32'h1_0000, 1'b0, 32'h0, 1'b0, 1'b0);
    readCheck(cmdIoRead, ioBase, 1'b0, 32'h0000_4F49, 1'b1, 1'b0);
    readCheck(cmdMemRead, memBase, 1'b0, 32'h004D_454D, 1'b1, 1'b0);
    endTest("decode");

    writeDo(cmdIoWrite, ioBase + 32'h4, 1'b0, 32'h0000_0028, 1'b0);  // 5 at AD[5:3]
    checkValue("LED", LED, 2'b01);
    readCheck(cmdIoRead, ioBase + 32'h4, 1'b0, 32'h0000_0028, 1'b1, 1'b0);
    readCheck(cmdMemRead, memBase + 32'h4, 1'b0, 32'h0000_0005, 1'b1, 1'b0);
    writeDo(cmdMemWrite, memBase + 32'h4, 1'b0, 32'h0000_0006, 1'b0);  // 6 at AD[2:0]
    checkValue("LED", LED, 2'b10);
    readCheck(cmdIoRead, ioBase + 32'h4, 1'b0, 32'h0000_0030, 1'b1, 1'b0);
    endTest("LED register views");

    wrBuf[0] = 32'hCAFE_F00D;
    wrBuf[1] = 32'h1234_5678;  // lands on an unmapped dword
    busXfer(cmdMemWrite, memBase + 32'h8, 1'b0, 2, 1'b1, 1'b0, 1'b1);
    busXfer(cmdMemReadMultiple, memBase, 1'b0, 4, 1'b1, 1'b0, 1'b1);
    checkValue("burst dword 0", rdBuf[0], 32'h004D_454D);
    checkValue("burst dword 1", rdBuf[1], 32'h0000_0006);
    checkValue("burst dword 2", rdBuf[2], 32'hCAFE_F00D);
    checkValue("burst dword 3", rdBuf[3], 32'h0);
    endTest("burst with wait states");

    writeDo(cmdIoWrite, ioBase + 32'h8, 1'b0, 32'h0BAD_BEEF, 1'b1);
    readCheck(cmdMemRead, memBase + 32'h8, 1'b0, 32'h0BAD_BEEF, 1'b1, 1'b1);
    readCheck(cmdCfgRead, 32'h4, 1'b1, 32'h0000_0003, 1'b1, 1'b0);
    endTest("back-to-back");

    repeat (2) @(negedge PCI_CLK);
    total = errors + UUT.protoChecks.failCount;
    $display("%0d tests, %0d failed, %0d value errors, %0d assertion failures",
             testsRun, testsFailed, errors, UUT.protoChecks.failCount);
    if (total == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
pciBusPkg.sv
pciDevicePkg.sv
pciTargetCtrl.sv
pciConfigSpace.sv
pciUserRegs.sv
pciTarget.sv
pciTarget_asserts.sv
tbPciTarget.sv
